/* Bender.yml */
package:
  name: pe_control_unit

sources:
  - common/pe_ctrl_pkg.sv
  - common/fifo_if.sv
  - hdl/sync_fifo.sv
  - hdl/param_decode.sv
  - hdl/mac_sequencer.sv
  - hdl/buffer_fetch.sv
  - hdl/output_writer.sv
  - hdl/pe_control_unit.sv
  - target: test
    files:
      - verification/pe_control_unit_sva.sv
      - verification/tb_pe_control_unit.sv

/* common/fifo_if.sv */
// ==========================================================
// one FIFO's write side, read side and flags
// producer and consumer modports face the FIFO's fifo_end
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

interface fifo_if import pe_ctrl_pkg::*; ();

  logic  wr;
  data_t wr_data;
  logic  full;
  logic  rd;
  data_t rd_data;
  logic  empty;

  modport producer (
    output wr,
    output wr_data,
    input  full
  );

  modport consumer (
    output rd,
    input  rd_data,
    input  empty
  );

  modport fifo_end (
    input  wr,
    input  wr_data,
    input  rd,
    output full,
    output rd_data,
    output empty
  );

endinterface

`default_nettype wire

/* common/pe_ctrl_pkg.sv */
// ==========================================================
// shared types, field positions and FSM encodings for the
// PE control unit, imported by every block of the design
// ==========================================================
`default_nettype none

package pe_ctrl_pkg;

  localparam int DATA_W     = 32;
  localparam int BYTE_LEN   = 8;
  localparam int WORD_BYTES = DATA_W / BYTE_LEN;
  localparam int PARAM_W    = 4;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [31:0]        addr_t;
  typedef logic [PARAM_W-1:0] param_t;

  // parameter word layout
  localparam int P_R_LSB      = 0;
  localparam int P_S_LSB      = 4;
  localparam int P_STRIDE_LSB = 8;
  localparam int P_TILE_LSB   = 12;
  localparam int P_CH_LSB     = 16;
  localparam int P_CH_MSB     = 27;
  localparam int P_SOFT_RESET = 29;
  localparam int P_START      = 30;
  localparam int P_VALID      = 31;

  // memory control word
  localparam int MC_BUF_WEIGHTS = 0;
  localparam int MC_BUF_INPUTS  = 3;
  localparam int MC_CLR_OUTPUT  = 5;
  localparam int MC_BUF_PSUMS   = 6;
  localparam int MC_CLR_PSUM    = 7;

  typedef enum logic [1:0] {NONE, WEIGHTS, INPUTS, PSUMS} fetch_kind_e;

  // bursts of BURST_LEN beats per fetch kind
  localparam int WEIGHT_BURSTS = 1;
  localparam int INPUT_BURSTS  = 2;
  localparam int PSUM_BURSTS   = 3;

  typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_WAIT, RD_DONE} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_ISSUE, WR_WAIT, WR_DONE} wr_state_e;
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_FILL, SEQ_RUN, SEQ_CAPTURE} seq_state_e;

  // status word
  localparam int ST_WEIGHTS_BUF = 0;
  localparam int ST_INPUTS_BUF  = 1;
  localparam int ST_PSUMS_BUF   = 2;
  localparam int ST_OUT_WRITTEN = 3;
  localparam int ST_BUSY        = 4;
  localparam int ST_WEIGHT_ERR  = 16;
  localparam int ST_INPUT_ERR   = 17;
  localparam int ST_PSUM_ERR    = 18;
  localparam int ST_OUTPUT_ERR  = 19;

endpackage

`default_nettype wire

/* compile.f */
common/pe_ctrl_pkg.sv
common/fifo_if.sv
hdl/sync_fifo.sv
hdl/param_decode.sv
hdl/mac_sequencer.sv
hdl/buffer_fetch.sv
hdl/output_writer.sv
hdl/pe_control_unit.sv
verification/pe_control_unit_sva.sv
verification/tb_pe_control_unit.sv

/* hdl/buffer_fetch.sv */
// ==========================================================
// read FSM: turns buffer requests into memory read bursts
// and steers beats to weight, activation or psum targets
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module buffer_fetch import pe_ctrl_pkg::*; #(
  parameter int BURST_LEN = 16
) (
  input  logic     CLK,
  input  logic     RESETN,
  input  data_t    mem_ctrl,
  input  addr_t    weight_base,
  input  addr_t    input_base,
  input  addr_t    psum_base,
  input  logic     rd_beat,
  input  data_t    rd_data,
  input  logic     txn_done,
  input  logic     axi_error,
  output logic     init_rd_txn,
  output addr_t    rd_addr,
  output logic     weight_wr,
  output logic     act_wr,
  output logic     weights_buffered,
  output logic     inputs_buffered,
  output logic     psums_buffered,
  output logic     weight_err,
  output logic     input_err,
  output logic     psum_err,
  fifo_if.producer psum_q
);

  rd_state_e   state_q;
  fetch_kind_e kind_q;
  fetch_kind_e grant_kind;
  logic [1:0]  burst_idx;
  logic [1:0]  n_bursts;
  addr_t       base;
  logic [2:0]  buf_req;
  logic [2:0]  buf_prev_q;
  logic [2:0]  pend_q;
  logic [2:0]  grant;
  logic [2:0]  sel;
  logic [2:0]  flag_q;
  logic [2:0]  err_q;
  logic [2:0]  err_set;
  logic        beat_ok;

  // bit order everywhere is {psums, inputs, weights}
  assign buf_req = {mem_ctrl[MC_BUF_PSUMS], mem_ctrl[MC_BUF_INPUTS], mem_ctrl[MC_BUF_WEIGHTS]};
  assign sel     = {kind_q == PSUMS, kind_q == INPUTS, kind_q == WEIGHTS};

  // fixed priority among pending requests
  always_comb begin
    if (pend_q[0]) grant_kind = WEIGHTS;
    else if (pend_q[1]) grant_kind = INPUTS;
    else if (pend_q[2]) grant_kind = PSUMS;
    else grant_kind = NONE;
  end

  assign grant = (state_q == RD_IDLE) ?
      {grant_kind == PSUMS, grant_kind == INPUTS, grant_kind == WEIGHTS} : 3'b000;

  always_comb begin
    case (kind_q)
      WEIGHTS: begin
        base     = weight_base;
        n_bursts = 2'(WEIGHT_BURSTS);
      end
      INPUTS: begin
        base     = input_base;
        n_bursts = 2'(INPUT_BURSTS);
      end
      PSUMS: begin
        base     = psum_base;
        n_bursts = 2'(PSUM_BURSTS);
      end
      default: begin
        base     = '0;
        n_bursts = 2'd0;
      end
    endcase
  end

  assign init_rd_txn = state_q == RD_ISSUE;
  assign rd_addr     = base + addr_t'(burst_idx) * addr_t'(BURST_LEN * WORD_BYTES);

  assign beat_ok        = state_q == RD_WAIT && rd_beat;
  assign weight_wr      = beat_ok && kind_q == WEIGHTS;
  assign act_wr         = beat_ok && kind_q == INPUTS;
  assign psum_q.wr      = beat_ok && kind_q == PSUMS;
  assign psum_q.wr_data = rd_data;

  // bus error at burst end, or a psum beat that finds the FIFO full
  always_comb begin
    err_set = 3'b000;
    if (state_q == RD_WAIT && txn_done && axi_error) err_set = sel;
    if (psum_q.wr && psum_q.full) err_set[2] = 1'b1;
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state_q    <= RD_IDLE;
      kind_q     <= NONE;
      burst_idx  <= '0;
      buf_prev_q <= '0;
      pend_q     <= '0;
      flag_q     <= '0;
      err_q      <= '0;
    end else begin
      buf_prev_q <= buf_req;
      pend_q     <= (pend_q & ~grant) | (buf_req & ~buf_prev_q);
      flag_q     <= flag_q & ~grant;
      err_q      <= (err_q & ~grant) | err_set;
      case (state_q)
        RD_IDLE: begin
          if (grant_kind != NONE) begin
            kind_q    <= grant_kind;
            burst_idx <= '0;
            state_q   <= RD_ISSUE;
          end
        end
        RD_ISSUE: state_q <= RD_WAIT;
        RD_WAIT: begin
          if (txn_done) begin
            burst_idx <= burst_idx + 1'b1;
            if (burst_idx == n_bursts - 2'd1) flag_q <= flag_q | sel;
            state_q <= RD_DONE;
          end
        end
        RD_DONE: begin
          // one idle cycle between bursts
          if (burst_idx == n_bursts) begin
            kind_q  <= NONE;
            state_q <= RD_IDLE;
          end else begin
            state_q <= RD_ISSUE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  assign weights_buffered = flag_q[0];
  assign inputs_buffered  = flag_q[1];
  assign psums_buffered   = flag_q[2];
  assign weight_err       = err_q[0];
  assign input_err        = err_q[1];
  assign psum_err         = err_q[2];

endmodule

`default_nettype wire

/* hdl/mac_sequencer.sv */
// ==========================================================
// MAC array run control: pipeline fill, tile sweep, stall
// and capture of the array's output psums into the out FIFO
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module mac_sequencer import pe_ctrl_pkg::*; #(
  parameter int MAC_PIPE_DEPTH = 2
) (
  input  logic     CLK,
  input  logic     RESETN,
  input  logic     start_pulse,
  input  param_t   r,
  input  param_t   tile,
  input  logic     act_valid,
  input  data_t    out_psum,
  output logic     stall,
  output data_t    in_psum,
  output logic     busy,
  output logic     capture_done,
  fifo_if.consumer psum_q,
  fifo_if.producer out_q
);

  localparam int PIPE_W = $clog2(MAC_PIPE_DEPTH + 1);

  seq_state_e        state_q;
  logic [PIPE_W-1:0] pipe_cnt;
  param_t            col_cnt;
  param_t            row_cnt;
  logic [7:0]        cap_cnt;
  logic [7:0]        cap_len;

  assign cap_len = tile * r;
  assign busy    = state_q != SEQ_IDLE;

  // array waits on missing activations, except while draining outputs
  assign stall = !act_valid && (state_q == SEQ_FILL || state_q == SEQ_RUN);

  // one input psum per valid activation
  assign psum_q.rd     = act_valid;
  assign in_psum       = psum_q.rd_data;
  assign out_q.wr      = state_q == SEQ_CAPTURE;
  assign out_q.wr_data = out_psum;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state_q      <= SEQ_IDLE;
      pipe_cnt     <= '0;
      col_cnt      <= '0;
      row_cnt      <= '0;
      cap_cnt      <= '0;
      capture_done <= 1'b0;
    end else begin
      capture_done <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          if (start_pulse) begin
            pipe_cnt <= '0;
            col_cnt  <= '0;
            row_cnt  <= '0;
            cap_cnt  <= '0;
            state_q  <= SEQ_FILL;
          end
        end
        SEQ_FILL: begin
          if (act_valid) begin
            if (pipe_cnt == PIPE_W'(MAC_PIPE_DEPTH - 1)) begin
              state_q <= SEQ_RUN;
            end else begin
              pipe_cnt <= pipe_cnt + 1'b1;
            end
          end
        end
        SEQ_RUN: begin
          // tile columns per row, rows 0..R
          if (act_valid) begin
            if (col_cnt == tile - 4'd1) begin
              col_cnt <= '0;
              if (row_cnt == r) begin
                state_q <= SEQ_CAPTURE;
              end else begin
                row_cnt <= row_cnt + 1'b1;
              end
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
          end
        end
        SEQ_CAPTURE: begin
          cap_cnt <= cap_cnt + 1'b1;
          if (cap_cnt + 8'd1 >= cap_len) begin
            capture_done <= 1'b1;
            state_q      <= SEQ_IDLE;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/output_writer.sv */
// ==========================================================
// write FSM: drains captured output psums to memory in
// bursts of BURST_LEN words once capture has finished
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module output_writer import pe_ctrl_pkg::*; #(
  parameter int BURST_LEN = 16
) (
  input  logic     CLK,
  input  logic     RESETN,
  input  logic     capture_done,
  input  logic     start_pulse,
  input  param_t   r,
  input  param_t   tile,
  input  addr_t    output_base,
  input  logic     wr_beat,
  input  logic     txn_done,
  input  logic     axi_error,
  output logic     init_wr_txn,
  output addr_t    wr_addr,
  output data_t    wr_data,
  output logic     output_written,
  output logic     output_err,
  fifo_if.consumer out_q
);

  wr_state_e  state_q;
  logic [7:0] out_len;
  logic [7:0] n_bursts;
  logic [7:0] n_bursts_q;
  logic [7:0] burst_idx;

  // ceiling of tile*R words over the burst length
  assign out_len  = tile * r;
  assign n_bursts = 8'((int'(out_len) + BURST_LEN - 1) / BURST_LEN);

  assign init_wr_txn = state_q == WR_ISSUE;
  assign wr_addr     = output_base + addr_t'(burst_idx) * addr_t'(BURST_LEN * WORD_BYTES);
  assign out_q.rd    = wr_beat && state_q == WR_WAIT;
  assign wr_data     = out_q.empty ? '0 : out_q.rd_data;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state_q        <= WR_IDLE;
      n_bursts_q     <= '0;
      burst_idx      <= '0;
      output_written <= 1'b0;
      output_err     <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (start_pulse) begin
            output_written <= 1'b0;
            output_err     <= 1'b0;
          end
          if (capture_done) begin
            n_bursts_q <= n_bursts;
            burst_idx  <= '0;
            if (n_bursts == '0) begin
              output_written <= 1'b1;
            end else begin
              state_q <= WR_ISSUE;
            end
          end
        end
        WR_ISSUE: state_q <= WR_WAIT;
        WR_WAIT: begin
          if (txn_done) begin
            if (axi_error) output_err <= 1'b1;
            if (burst_idx == n_bursts_q - 8'd1) output_written <= 1'b1;
            burst_idx <= burst_idx + 8'd1;
            state_q   <= WR_DONE;
          end
        end
        WR_DONE: begin
          if (burst_idx == n_bursts_q) begin
            state_q <= WR_IDLE;
          end else begin
            state_q <= WR_ISSUE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/param_decode.sv */
// ==========================================================
// decodes the accelerator parameter word into array mux
// settings on valid, and flags the rising edge of start
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module param_decode import pe_ctrl_pkg::*; #(
  parameter int PE_ROWS = 5,
  parameter int PE_COLS = 5
) (
  input  logic                       CLK,
  input  logic                       RESETN,
  input  data_t                      acc_params,
  output param_t                     r,
  output param_t                     s,
  output param_t                     tile,
  output logic [PE_ROWS*PE_COLS-1:0] add_mux_ctrl,
  output logic [PE_ROWS*4-1:0]       row_out_mux_ctrl,
  output logic [2:0]                 psum_out_mux_ctrl,
  output logic                       start_pulse
);

  localparam int CH_W = P_CH_MSB - P_CH_LSB + 1;

  param_t r_in;
  param_t s_in;
  param_t tile_in;
  logic   start_q;

  // stride and channels are not used here, only checked to fit the word
  if (P_STRIDE_LSB + PARAM_W > P_TILE_LSB || P_CH_LSB + CH_W > P_SOFT_RESET ||
      PE_ROWS > 8) begin : g_layout_err
    $error("parameter word layout does not fit the array");
  end

  assign r_in    = acc_params[P_R_LSB +: PARAM_W];
  assign s_in    = acc_params[P_S_LSB +: PARAM_W];
  assign tile_in = acc_params[P_TILE_LSB +: PARAM_W];

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      r                 <= '0;
      s                 <= '0;
      tile              <= '0;
      add_mux_ctrl      <= '0;
      row_out_mux_ctrl  <= '0;
      psum_out_mux_ctrl <= '0;
    end else if (acc_params[P_VALID]) begin
      r    <= r_in;
      s    <= s_in;
      tile <= tile_in;
      for (int row = 0; row < PE_ROWS; row++) begin
        // adders active in the first S columns of the first R rows
        for (int col = 0; col < PE_COLS; col++) begin
          add_mux_ctrl[row*PE_COLS + col] <= (col < s_in) && (row < r_in);
        end
        row_out_mux_ctrl[row*4 +: 4] <= tile_in - 4'd1;
      end
      psum_out_mux_ctrl <= 3'(r_in - 4'd1);
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      start_q     <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      start_q     <= acc_params[P_START];
      start_pulse <= acc_params[P_START] && !start_q;
    end
  end

endmodule

`default_nettype wire

/* hdl/pe_control_unit.sv */
// ==========================================================
// PE control unit top: parameter decode, fetch, MAC run
// control, output write-back and the status word
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module pe_control_unit import pe_ctrl_pkg::*; #(
  parameter int PE_ROWS        = 5,
  parameter int PE_COLS        = 5,
  parameter int MAC_PIPE_DEPTH = 2,
  parameter int BURST_LEN      = 16,
  parameter int FIFO_DEPTH     = 64
) (
  input  logic                       CLK,
  input  logic                       RESETN,
  input  data_t                      acc_params,
  input  addr_t                      weight_base_addr,
  input  addr_t                      input_base_addr,
  input  addr_t                      output_base_addr,
  input  data_t                      mem_ctrl,
  output data_t                      pe_status,
  // array side
  output logic                       resetn_mac,
  output logic [PE_ROWS*PE_COLS-1:0] add_mux_ctrl,
  output logic [PE_ROWS*4-1:0]       row_out_mux_ctrl,
  output logic [2:0]                 psum_out_mux_ctrl,
  output logic                       stall,
  output data_t                      in_psum_out,
  input  data_t                      out_psum_in,
  input  logic                       act_valid,
  output logic                       weight_wr,
  output logic                       act_wr,
  // memory master
  output addr_t                      rd_addr,
  output addr_t                      wr_addr,
  input  data_t                      rd_data,
  input  logic                       rd_beat,
  output data_t                      wr_data,
  input  logic                       wr_beat,
  output logic                       init_rd_txn,
  output logic                       init_wr_txn,
  input  logic                       txn_done,
  input  logic                       axi_error
);

  logic       resetn_soft;
  logic [1:0] clr_prev_q;
  logic       clr_out;
  logic       clr_psum;
  param_t     r;
  param_t     tile;
  logic       start_pulse;
  logic       busy;
  logic       capture_done;
  logic       weights_buffered;
  logic       inputs_buffered;
  logic       psums_buffered;
  logic       output_written;
  logic       weight_err;
  logic       input_err;
  logic       psum_err;
  logic       output_err;
  data_t      status_d;

  fifo_if psum_q ();
  fifo_if out_q ();

  assign resetn_soft = RESETN && !acc_params[P_SOFT_RESET];
  assign resetn_mac  = resetn_soft;

  // FIFO clears on the rising edge of their control bits
  always_ff @(posedge CLK) begin
    if (!resetn_soft) begin
      clr_prev_q <= '0;
    end else begin
      clr_prev_q <= {mem_ctrl[MC_CLR_PSUM], mem_ctrl[MC_CLR_OUTPUT]};
    end
  end

  assign clr_out  = mem_ctrl[MC_CLR_OUTPUT] && !clr_prev_q[0];
  assign clr_psum = mem_ctrl[MC_CLR_PSUM] && !clr_prev_q[1];

  param_decode #(.PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS)) param_decode_inst (
    .CLK(CLK), .RESETN(resetn_soft), .acc_params(acc_params),
    .r(r), .s(), .tile(tile),
    .add_mux_ctrl(add_mux_ctrl), .row_out_mux_ctrl(row_out_mux_ctrl),
    .psum_out_mux_ctrl(psum_out_mux_ctrl), .start_pulse(start_pulse)
  );

  // psums are read back from the output region
  buffer_fetch #(.BURST_LEN(BURST_LEN)) buffer_fetch_inst (
    .CLK(CLK), .RESETN(RESETN), .mem_ctrl(mem_ctrl),
    .weight_base(weight_base_addr), .input_base(input_base_addr),
    .psum_base(output_base_addr),
    .rd_beat(rd_beat), .rd_data(rd_data), .txn_done(txn_done), .axi_error(axi_error),
    .init_rd_txn(init_rd_txn), .rd_addr(rd_addr),
    .weight_wr(weight_wr), .act_wr(act_wr),
    .weights_buffered(weights_buffered), .inputs_buffered(inputs_buffered),
    .psums_buffered(psums_buffered),
    .weight_err(weight_err), .input_err(input_err), .psum_err(psum_err),
    .psum_q(psum_q)
  );

  sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) psum_fifo_inst (
    .CLK(CLK), .RESETN(resetn_soft), .clear(clr_psum), .q(psum_q)
  );

  mac_sequencer #(.MAC_PIPE_DEPTH(MAC_PIPE_DEPTH)) mac_sequencer_inst (
    .CLK(CLK), .RESETN(resetn_soft), .start_pulse(start_pulse),
    .r(r), .tile(tile), .act_valid(act_valid), .out_psum(out_psum_in),
    .stall(stall), .in_psum(in_psum_out), .busy(busy), .capture_done(capture_done),
    .psum_q(psum_q), .out_q(out_q)
  );

  sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) out_fifo_inst (
    .CLK(CLK), .RESETN(resetn_soft), .clear(clr_out), .q(out_q)
  );

  output_writer #(.BURST_LEN(BURST_LEN)) output_writer_inst (
    .CLK(CLK), .RESETN(RESETN), .capture_done(capture_done), .start_pulse(start_pulse),
    .r(r), .tile(tile), .output_base(output_base_addr),
    .wr_beat(wr_beat), .txn_done(txn_done), .axi_error(axi_error),
    .init_wr_txn(init_wr_txn), .wr_addr(wr_addr), .wr_data(wr_data),
    .output_written(output_written), .output_err(output_err), .out_q(out_q)
  );

  always_comb begin
    status_d                 = '0;
    status_d[ST_WEIGHTS_BUF] = weights_buffered;
    status_d[ST_INPUTS_BUF]  = inputs_buffered;
    status_d[ST_PSUMS_BUF]   = psums_buffered;
    status_d[ST_OUT_WRITTEN] = output_written;
    status_d[ST_BUSY]        = busy;
    status_d[ST_WEIGHT_ERR]  = weight_err;
    status_d[ST_INPUT_ERR]   = input_err;
    status_d[ST_PSUM_ERR]    = psum_err;
    status_d[ST_OUTPUT_ERR]  = output_err;
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      pe_status <= '0;
    end else begin
      pe_status <= status_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/sync_fifo.sv */
// ==========================================================
// first-word-fall-through FIFO with synchronous clear
// head word is visible whenever empty is low
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module sync_fifo import pe_ctrl_pkg::*; #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic     CLK,
  input  logic     RESETN,
  input  logic     clear,
  fifo_if.fifo_end q
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = PTR_W + 1;

  data_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign q.full    = count == CNT_W'(FIFO_DEPTH);
  assign q.empty   = count == '0;
  assign q.rd_data = mem[rd_ptr];

  // writes into a full FIFO and reads from an empty one are ignored
  assign do_wr = q.wr && !q.full;
  assign do_rd = q.rd && !q.empty;

  always_ff @(posedge CLK) begin
    if (!RESETN || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= next_ptr(wr_ptr);
      if (do_rd) rd_ptr <= next_ptr(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (do_wr) mem[wr_ptr] <= q.wr_data;
  end

endmodule

`default_nettype wire

/* verification/pe_control_unit_sva.sv */
// ==========================================================
// memory-master handshake and stall assertions, bound to
// the PE control unit top level
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module pe_control_unit_sva import pe_ctrl_pkg::*; (
  input wire        CLK,
  input wire        RESETN,
  input wire        init_rd_txn,
  input wire        init_wr_txn,
  input wire        stall,
  input seq_state_e seq_state
);

  // init pulses last a single cycle
  assert property (@(posedge CLK) disable iff (!RESETN) init_rd_txn |=> !init_rd_txn)
    else $error("init_rd_txn high for more than one cycle");
  assert property (@(posedge CLK) disable iff (!RESETN) init_wr_txn |=> !init_wr_txn)
    else $error("init_wr_txn high for more than one cycle");

  assert property (@(posedge CLK) disable iff (!RESETN) !(init_rd_txn && init_wr_txn))
    else $error("read and write init high together");

  assert property (@(posedge CLK) (!RESETN ##1 !RESETN) |-> !init_rd_txn && !init_wr_txn)
    else $error("init pulse during reset");

  assert property (@(posedge CLK) disable iff (!RESETN) seq_state == SEQ_CAPTURE |-> !stall)
    else $error("stall high during capture");

endmodule

bind pe_control_unit pe_control_unit_sva pe_control_unit_sva_inst (
  .CLK(CLK),
  .RESETN(RESETN),
  .init_rd_txn(init_rd_txn),
  .init_wr_txn(init_wr_txn),
  .stall(stall),
  .seq_state(mac_sequencer_inst.state_q)
);

`default_nettype wire

/* verification/tb_pe_control_unit.sv */
// ==========================================================
// directed testbench for the PE control unit, with a simple
// memory-master model answering read and write bursts
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_pe_control_unit;
  import pe_ctrl_pkg::*;

  localparam int PE_ROWS   = 5;
  localparam int PE_COLS   = 5;
  localparam int BURST_LEN = 16;
  localparam int PERIOD    = 40;
  // rough cycle budget per test, doubled by the watchdog
  localparam int RUN_CYCLES = 20 + 120 + 120 + 300 + 80;

  logic CLK;
  logic RESETN;
  data_t acc_params;
  addr_t weight_base_addr;
  addr_t input_base_addr;
  addr_t output_base_addr;
  data_t mem_ctrl;
  data_t pe_status;
  logic resetn_mac;
  logic [PE_ROWS*PE_COLS-1:0] add_mux_ctrl;
  logic [PE_ROWS*4-1:0] row_out_mux_ctrl;
  logic [2:0] psum_out_mux_ctrl;
  logic stall;
  data_t in_psum_out;
  data_t out_psum_in;
  logic act_valid;
  logic weight_wr;
  logic act_wr;
  addr_t rd_addr;
  addr_t wr_addr;
  data_t rd_data;
  logic rd_beat;
  data_t wr_data;
  logic wr_beat;
  logic init_rd_txn;
  logic init_wr_txn;
  logic txn_done;
  logic axi_error;

  int seed = 61528;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int burst_no = 0;
  int err_burst = -1;
  int n_weight_wr = 0;
  int n_act_wr = 0;
  addr_t rd_addrs[$];
  addr_t wr_addrs[$];
  data_t rd_words[$];
  data_t wr_words[$];
  data_t cap_words[$];

  pe_control_unit #(.PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .BURST_LEN(BURST_LEN))
    pe_control_unit_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    if (weight_wr === 1'b1) n_weight_wr++;
    if (act_wr === 1'b1) n_act_wr++;
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mux(input string name, input logic [PE_ROWS*PE_COLS-1:0] got,
                           input logic [PE_ROWS*PE_COLS-1:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_status(input int idx, input logic value, input string what);
    int n;
    n = 0;
    while (pe_status[idx] !== value && n < 400) begin
      @(negedge CLK);
      n++;
    end
    if (pe_status[idx] !== value) begin
      $display("%s did not happen within 400 cycles", what);
      errors++;
    end
  endtask

  // one burst of the memory master, starting right after the init pulse
  task automatic run_burst(input logic is_wr);
    if (is_wr) wr_addrs.push_back(wr_addr);
    else rd_addrs.push_back(rd_addr);
    for (int i = 0; i < BURST_LEN; i++) begin
      @(negedge CLK);
      if (is_wr) begin
        wr_beat = 1'b1;
        #1 wr_words.push_back(wr_data);
      end else begin
        rd_data = $random(seed);
        rd_beat = 1'b1;
        rd_words.push_back(rd_data);
      end
    end
    @(negedge CLK);
    rd_beat   = 1'b0;
    wr_beat   = 1'b0;
    txn_done  = 1'b1;
    axi_error = burst_no == err_burst;
    burst_no++;
    @(negedge CLK);
    txn_done  = 1'b0;
    axi_error = 1'b0;
  endtask

  initial begin
    rd_beat   = 1'b0;
    wr_beat   = 1'b0;
    rd_data   = '0;
    txn_done  = 1'b0;
    axi_error = 1'b0;
    forever begin
      @(negedge CLK);
      if (init_rd_txn === 1'b1 || init_wr_txn === 1'b1) run_burst(init_wr_txn === 1'b1);
    end
  end

  // pulse one memory-control bit for a cycle
  task automatic pulse_ctrl(input int idx);
    @(negedge CLK);
    mem_ctrl[idx] = 1'b1;
    @(negedge CLK);
    mem_ctrl[idx] = 1'b0;
  endtask

  task automatic param_decode_test();
    logic [PE_ROWS*PE_COLS-1:0] exp_add;
    logic [PE_ROWS*4-1:0] exp_row;
    exp_add = '0;
    for (int row = 0; row < PE_ROWS; row++) begin
      for (int col = 0; col < PE_COLS; col++) exp_add[row*PE_COLS + col] = col < 2 && row < 3;
      exp_row[row*4 +: 4] = 4'd3;
    end
    @(negedge CLK);
    acc_params = 32'h8000_4023;
    @(negedge CLK);
    check_mux("add_mux_ctrl", add_mux_ctrl, exp_add);
    check_mux("row_out_mux_ctrl", row_out_mux_ctrl, exp_row);
    check_mux("psum_out_mux_ctrl", psum_out_mux_ctrl, 3'd2);
    check_data("resetn_mac", resetn_mac, 1'b1);
    // soft reset clears the mux settings
    acc_params[P_SOFT_RESET] = 1'b1;
    @(negedge CLK);
    check_data("resetn_mac", resetn_mac, 1'b0);
    acc_params = '0;
    check_mux("add_mux_ctrl", add_mux_ctrl, '0);
    check_mux("row_out_mux_ctrl", row_out_mux_ctrl, '0);
    check_mux("psum_out_mux_ctrl", psum_out_mux_ctrl, '0);
  endtask

  task automatic weight_input_fetch_test();
    rd_addrs.delete();
    n_weight_wr = 0;
    pulse_ctrl(MC_BUF_WEIGHTS);
    wait_status(ST_WEIGHTS_BUF, 1'b1, "weights buffered flag");
    check_data("weight bursts", rd_addrs.size(), 1);
    check_addr("rd_addr", rd_addrs[0], 32'h1000);
    check_data("weight_wr count", n_weight_wr, 16);
    rd_addrs.delete();
    n_act_wr = 0;
    pulse_ctrl(MC_BUF_INPUTS);
    wait_status(ST_INPUTS_BUF, 1'b1, "inputs buffered flag");
    check_data("input bursts", rd_addrs.size(), 2);
    check_addr("rd_addr", rd_addrs[0], 32'h2000);
    check_addr("rd_addr", rd_addrs[1], 32'h2040);
    check_data("act_wr count", n_act_wr, 32);
  endtask

  task automatic psum_error_test();
    err_burst = burst_no + 1;
    pulse_ctrl(MC_BUF_PSUMS);
    wait_status(ST_PSUMS_BUF, 1'b1, "psums buffered flag");
    err_burst = -1;
    check_data("pe_status psum bits", pe_status & 32'h0004_0004, 32'h0004_0004);
  endtask

  task automatic mac_run_test();
    int nvalid;
    int n;
    pulse_ctrl(MC_CLR_PSUM);
    rd_words.delete();
    pulse_ctrl(MC_BUF_PSUMS);
    wait_status(ST_PSUMS_BUF, 1'b0, "psums flag clear");
    wait_status(ST_PSUMS_BUF, 1'b1, "psums buffered flag");
    acc_params = 32'h8000_4023;
    @(negedge CLK);
    acc_params[P_START] = 1'b1;
    n = 0;
    while (stall !== 1'b1 && n < 20) begin
      @(negedge CLK);
      #1 n++;
    end
    if (stall !== 1'b1) begin
      $display("sequencer never entered its fill phase");
      errors++;
    end
    acc_params[P_START] = 1'b0;
    // FILL takes 2 valid cycles and RUN 4*(3+1)
    nvalid = 0;
    while (nvalid < 18) begin
      @(negedge CLK);
      act_valid = $random(seed);
      #1 check_data("stall", stall, !act_valid);
      if (act_valid) begin
        check_data("in_psum_out", in_psum_out, rd_words[nvalid]);
        nvalid++;
      end
    end
    cap_words.delete();
    for (int i = 0; i < 12; i++) begin
      @(negedge CLK);
      act_valid   = 1'b0;
      out_psum_in = $random(seed);
      cap_words.push_back(out_psum_in);
      #1 check_data("stall", stall, 1'b0);
    end
  endtask

  task automatic output_write_test();
    wait_status(ST_OUT_WRITTEN, 1'b1, "output written flag");
    check_data("write bursts", wr_addrs.size(), 1);
    check_addr("wr_addr", wr_addrs[0], 32'h3000);
    for (int i = 0; i < 12; i++) check_data("wr_data", wr_words[i], cap_words[i]);
    // beats past the captured words find the FIFO empty
    for (int i = 12; i < BURST_LEN; i++) check_data("wr_data", wr_words[i], '0);
    check_data("pe_status busy", pe_status[ST_BUSY], 1'b0);
    // all four done flags set, no error flags
    check_data("pe_status", pe_status, 32'h0000_000F);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int e;
    RESETN = 1'b0;
    acc_params = '0;
    weight_base_addr = 32'h1000;
    input_base_addr = 32'h2000;
    output_base_addr = 32'h3000;
    mem_ctrl = '0;
    out_psum_in = '0;
    act_valid = 1'b0;
    repeat (5) @(negedge CLK);
    RESETN = 1'b1;
    e = errors;
    param_decode_test();
    report_test("param_decode", e);
    e = errors;
    weight_input_fetch_test();
    report_test("weight_input_fetch", e);
    e = errors;
    psum_error_test();
    report_test("psum_error", e);
    e = errors;
    mac_run_test();
    report_test("mac_run", e);
    e = errors;
    output_write_test();
    report_test("output_write", e);
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(2 * RUN_CYCLES * PERIOD);
    $display("run timed out before all tests finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
